// ==== verilog/idct_defines.svh ====
`ifndef IDCT_DEFINES_SVH
`define IDCT_DEFINES_SVH

// block geometry
`define BLOCK_DIM    8
`define IMG_WIDTH    320      // luma samples per line

// sram map, word addresses
`define SPRIME_BASE  76800    // start of the S' plane
`define RESULT_BASE  0

// cycles from address to read data
`define SRAM_LATENCY 2

// scaling of T before the write
`define T_SHIFT      8

`endif

// ==== verilog/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;
	typedef logic [4:0]  buf_addr_t;   // 32 words per block
	typedef logic [31:0] buf_word_t;   // lower sample index in [31:16]

endpackage

`default_nettype wire

// ==== verilog/idct_pkg.sv ====
`default_nettype none

// arithmetic types of the first idct pass
package idct_pkg;

	typedef logic signed [15:0] sample_t;    // one S' coefficient
	typedef logic signed [15:0] coeff_t;     // cosine constant
	typedef logic signed [31:0] product_t;
	typedef logic signed [31:0] acc_t;       // running sum of T
	typedef logic [5:0]         coeff_idx_t; // 8*k + j

endpackage

`default_nettype wire

// ==== verilog/idct_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module idct_controller (
	input  logic                 clock,
	input  logic                 resetn,
	input  logic                 start_i,
	input  logic                 fetch_done_i,
	input  logic                 compute_done_i,
	input  sram_pkg::sram_addr_t fetch_addr_i,
	input  sram_pkg::sram_addr_t wr_addr_i,
	input  sram_pkg::sram_data_t wr_data_i,
	input  logic                 wr_valid_i,
	output logic                 fetch_start_o,
	output logic                 compute_start_o,
	output sram_pkg::sram_addr_t sram_address_o,
	output sram_pkg::sram_data_t sram_write_data_o,
	output logic                 sram_we_n_o,
	output logic                 done_o
);
	typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_COMPUTE} state_t;

	state_t state;

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			state           <= ST_IDLE;
			fetch_start_o   <= 1'b0;
			compute_start_o <= 1'b0;
			done_o          <= 1'b0;
		end else begin
			fetch_start_o   <= 1'b0;
			compute_start_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						fetch_start_o <= 1'b1;
						done_o        <= 1'b0; // held until the next accepted start
						state         <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					if (fetch_done_i) begin
						compute_start_o <= 1'b1;
						state           <= ST_COMPUTE;
					end
				end
				ST_COMPUTE: begin
					if (compute_done_i) begin
						done_o <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// writer owns the port only while computing
	assign sram_address_o    = (state == ST_COMPUTE) ? wr_addr_i : fetch_addr_i;
	assign sram_write_data_o = wr_data_i;
	assign sram_we_n_o       = !((state == ST_COMPUTE) && wr_valid_i);

endmodule

`default_nettype wire

// ==== verilog/block_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module block_fetch (
	input  logic                 clock,
	input  logic                 resetn,
	input  logic                 start_i,
	input  logic [4:0]           block_row_i,
	input  logic [5:0]           block_col_i,
	input  sram_pkg::sram_data_t sram_read_data_i,
	output sram_pkg::sram_addr_t sram_addr_o,
	output sram_pkg::buf_addr_t  buf_addr_o,
	output sram_pkg::buf_word_t  buf_wdata_o,
	output logic                 buf_we_o,
	output logic                 fetch_done_o
);
	import sram_pkg::*;

	logic                     active;
	logic [2:0]               off_i, off_j;
	sram_addr_t               row_base;   // first sample of the current block line
	logic [`SRAM_LATENCY-1:0] vld_pipe;
	logic                     rd_valid;
	logic [5:0]               rd_cnt;     // samples received so far
	sram_data_t               even_q;

	assign sram_addr_o = row_base + sram_addr_t'(off_j);
	assign rd_valid    = vld_pipe[`SRAM_LATENCY-1];

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			active       <= 1'b0;
			off_i        <= '0;
			off_j        <= '0;
			row_base     <= '0;
			vld_pipe     <= '0;
			rd_cnt       <= '0;
			buf_we_o     <= 1'b0;
			fetch_done_o <= 1'b0;
		end else begin
			vld_pipe     <= {vld_pipe[`SRAM_LATENCY-2:0], active};
			buf_we_o     <= rd_valid && rd_cnt[0];
			fetch_done_o <= buf_we_o && (buf_addr_o == 5'd31);
			if (start_i) begin
				active <= 1'b1;
				off_i  <= '0;
				off_j  <= '0;
				rd_cnt <= '0;
				// row * 8 lines * 320 = row * 2560
				row_base <= sram_addr_t'(`SPRIME_BASE)
					+ (sram_addr_t'(block_row_i) << 11)
					+ (sram_addr_t'(block_row_i) << 9)
					+ (sram_addr_t'(block_col_i) << 3);
			end else if (active) begin
				off_j <= off_j + 3'd1;
				if (off_j == 3'(`BLOCK_DIM - 1)) begin
					off_i    <= off_i + 3'd1;
					row_base <= row_base + sram_addr_t'(`IMG_WIDTH); // next line
					if (off_i == 3'(`BLOCK_DIM - 1))
						active <= 1'b0;
				end
			end
			if (rd_valid)
				rd_cnt <= rd_cnt + 6'd1;
		end
	end

	// pair even sample with its odd partner
	always_ff @(posedge clock) begin
		if (rd_valid && !rd_cnt[0])
			even_q <= sram_read_data_i;
		if (rd_valid && rd_cnt[0]) begin
			buf_wdata_o <= {even_q, sram_read_data_i};
			buf_addr_o  <= rd_cnt[5:1];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sample_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_buffer (
	input  logic                clock,
	input  sram_pkg::buf_addr_t addr_a_i,
	input  sram_pkg::buf_word_t wdata_a_i,
	input  logic                we_a_i,
	input  sram_pkg::buf_addr_t addr_b_i,
	output sram_pkg::buf_word_t rdata_a_o,
	output sram_pkg::buf_word_t rdata_b_o
);
	import sram_pkg::*;

	buf_word_t mem [32]; // one 8x8 block, two samples a word

	always_ff @(posedge clock) begin
		if (we_a_i)
			mem[addr_a_i] <= wdata_a_i;
		rdata_a_o <= mem[addr_a_i]; // old data on a same-cycle write
		rdata_b_o <= mem[addr_b_i];
	end

endmodule

`default_nettype wire

// ==== verilog/dct_coeff_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module dct_coeff_rom (
	input  idct_pkg::coeff_idx_t idx_i,
	output idct_pkg::coeff_t     coeff_o
);
	import idct_pkg::*;

	logic [2:0] k, j;
	logic [6:0] prod_kj;
	logic [4:0] angle;   // (2j+1)*k in units of pi/16, mod 2pi
	logic [2:0] fold;
	logic       neg;
	coeff_t     mag;

	always_comb begin
		k       = idx_i[5:3];
		j       = idx_i[2:0];
		prod_kj = {3'b000, j, 1'b1} * {4'b0000, k};
		angle   = prod_kj[4:0];
		// second and third quadrant are negative
		neg     = angle[4] ^ angle[3];
		// odd quadrants mirror around pi/2
		fold    = angle[3] ? 3'd0 - angle[2:0] : angle[2:0];
		case (fold)
			3'd0:    mag = 16'sd1448; // row 0 lands here, scaled by 1/sqrt(2)
			3'd1:    mag = 16'sd2008;
			3'd2:    mag = 16'sd1892;
			3'd3:    mag = 16'sd1702;
			3'd4:    mag = 16'sd1448;
			3'd5:    mag = 16'sd1137;
			3'd6:    mag = 16'sd783;
			default: mag = 16'sd399;
		endcase
		coeff_o = neg ? -mag : mag;
	end

endmodule

`default_nettype wire

// ==== verilog/t_compute.sv ====
`timescale 1ns/1ps
`default_nettype none

module t_compute (
	input  logic                 clock,
	input  logic                 resetn,
	input  logic                 start_i,
	input  sram_pkg::buf_word_t  buf_rdata_a_i,
	input  sram_pkg::buf_word_t  buf_rdata_b_i,
	input  idct_pkg::coeff_t     coeff0_i,
	input  idct_pkg::coeff_t     coeff1_i,
	input  idct_pkg::coeff_t     coeff2_i,
	output sram_pkg::buf_addr_t  buf_addr_a_o,
	output sram_pkg::buf_addr_t  buf_addr_b_o,
	output idct_pkg::coeff_idx_t coeff_idx0_o,
	output idct_pkg::coeff_idx_t coeff_idx1_o,
	output idct_pkg::coeff_idx_t coeff_idx2_o,
	output idct_pkg::acc_t       t_value_o,
	output logic                 t_valid_o,
	output logic                 compute_done_o
);
	import idct_pkg::*;
	import sram_pkg::*;

	logic       running;  // T values still to start
	logic       pend;     // previous T waits for k6, k7
	logic       last_q;
	logic [1:0] ph;
	logic [5:0] ij;       // index of the T being accumulated
	logic [2:0] row, col;
	logic [2:0] j_prev;
	sample_t    s3_q;
	acc_t       acc;
	acc_t       psum;
	sample_t    op_s [3];
	coeff_t     op_c [3];
	product_t   prod [3];

	assign row = ij[5:3];
	assign col = ij[2:0];

	// ph0 finishes the previous T from words 2,3 and starts the reads of words 0,1
	always_comb begin
		case (ph)
			2'd0: begin
				op_s[0]      = sample_t'(buf_rdata_b_i[31:16]);  // k6
				op_s[1]      = sample_t'(buf_rdata_b_i[15:0]);   // k7
				op_s[2]      = '0;
				coeff_idx0_o = {3'd6, j_prev};
				coeff_idx1_o = {3'd7, j_prev};
				coeff_idx2_o = {3'd0, col};
				buf_addr_a_o = {row, 2'b00};
				buf_addr_b_o = {row, 2'b01};
			end
			2'd1: begin
				op_s[0]      = sample_t'(buf_rdata_a_i[31:16]);
				op_s[1]      = sample_t'(buf_rdata_a_i[15:0]);
				op_s[2]      = sample_t'(buf_rdata_b_i[31:16]);
				coeff_idx0_o = {3'd0, col};
				coeff_idx1_o = {3'd1, col};
				coeff_idx2_o = {3'd2, col};
				buf_addr_a_o = {row, 2'b10};
				buf_addr_b_o = {row, 2'b11};
			end
			default: begin
				op_s[0]      = s3_q;                             // held from ph1
				op_s[1]      = sample_t'(buf_rdata_a_i[31:16]);
				op_s[2]      = sample_t'(buf_rdata_a_i[15:0]);
				coeff_idx0_o = {3'd3, col};
				coeff_idx1_o = {3'd4, col};
				coeff_idx2_o = {3'd5, col};
				buf_addr_a_o = {row, 2'b10};  // reread so ph0 sees words 2,3
				buf_addr_b_o = {row, 2'b11};
			end
		endcase
	end

	// three multipliers
	always_comb begin
		op_c[0] = coeff0_i;
		op_c[1] = coeff1_i;
		op_c[2] = coeff2_i;
		psum    = '0;
		for (int n = 0; n < 3; n++) begin
			prod[n] = product_t'(op_s[n]) * product_t'(op_c[n]);
			psum    = psum + acc_t'(prod[n]);
		end
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			running        <= 1'b0;
			pend           <= 1'b0;
			last_q         <= 1'b0;
			ph             <= '0;
			ij             <= '0;
			t_valid_o      <= 1'b0;
			compute_done_o <= 1'b0;
		end else begin
			t_valid_o      <= 1'b0;
			compute_done_o <= t_valid_o && last_q;
			if (start_i) begin
				running <= 1'b1;
				pend    <= 1'b0;
				ph      <= '0;
				ij      <= '0;
			end else if (running || pend) begin
				ph <= (ph == 2'd2) ? 2'd0 : ph + 2'd1;
				if (ph == 2'd0 && pend) begin
					t_valid_o <= 1'b1;
					pend      <= 1'b0;
					last_q    <= !running;
				end
				if (ph == 2'd2) begin
					pend <= 1'b1;
					ij   <= ij + 6'd1;
					if (ij == 6'd63)
						running <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		case (ph)
			2'd0: begin
				if (pend)
					t_value_o <= acc + psum;
			end
			2'd1: begin
				acc  <= psum;
				s3_q <= sample_t'(buf_rdata_b_i[15:0]); // k3, word 1 gets replaced
			end
			default: begin
				acc    <= acc + psum;
				j_prev <= col;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/result_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module result_writer (
	input  logic                 clock,
	input  logic                 resetn,
	input  logic                 start_i,
	input  idct_pkg::acc_t       t_value_i,
	input  logic                 t_valid_i,
	output sram_pkg::sram_addr_t wr_addr_o,
	output sram_pkg::sram_data_t wr_data_o,
	output logic                 wr_valid_o
);
	import idct_pkg::*;
	import sram_pkg::*;

	acc_t       scaled;
	sram_addr_t next_addr; // row-major position of the next T

	assign scaled = t_value_i >>> `T_SHIFT; // arithmetic, keeps the sign

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			wr_valid_o <= 1'b0;
			wr_addr_o  <= sram_addr_t'(`RESULT_BASE);
			next_addr  <= sram_addr_t'(`RESULT_BASE);
		end else begin
			wr_valid_o <= t_valid_i;
			if (start_i)
				next_addr <= sram_addr_t'(`RESULT_BASE);
			else if (t_valid_i) begin
				wr_addr_o <= next_addr;
				next_addr <= next_addr + 18'd1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (t_valid_i)
			wr_data_o <= scaled[15:0]; // low half only
	end

endmodule

`default_nettype wire

// ==== verilog/idct_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module idct_top (
	input  logic                 clock,
	input  logic                 resetn,
	input  logic                 start_i,
	input  logic [4:0]           block_row_i,
	input  logic [5:0]           block_col_i,
	input  sram_pkg::sram_data_t sram_read_data_i,
	output sram_pkg::sram_addr_t sram_address_o,
	output sram_pkg::sram_data_t sram_write_data_o,
	output logic                 sram_we_n_o,
	output logic                 done_o
);
	import idct_pkg::*;
	import sram_pkg::*;

	logic       fetch_start, compute_start;
	logic       fetch_done, compute_done;
	sram_addr_t fetch_addr, wr_addr;
	sram_data_t wr_data;
	logic       wr_valid;

	buf_addr_t  fetch_buf_addr, comp_addr_a, comp_addr_b, buf_addr_a;
	buf_word_t  fetch_wdata, rdata_a, rdata_b;
	logic       fetch_we;

	coeff_idx_t rom_idx [3];
	coeff_t     rom_coeff [3];
	acc_t       t_value;
	logic       t_valid;

	idct_controller u_ctrl (
		.clock             (clock),
		.resetn            (resetn),
		.start_i           (start_i),
		.fetch_done_i      (fetch_done),
		.compute_done_i    (compute_done),
		.fetch_addr_i      (fetch_addr),
		.wr_addr_i         (wr_addr),
		.wr_data_i         (wr_data),
		.wr_valid_i        (wr_valid),
		.fetch_start_o     (fetch_start),
		.compute_start_o   (compute_start),
		.sram_address_o    (sram_address_o),
		.sram_write_data_o (sram_write_data_o),
		.sram_we_n_o       (sram_we_n_o),
		.done_o            (done_o)
	);

	block_fetch u_fetch (
		.clock            (clock),
		.resetn           (resetn),
		.start_i          (fetch_start),
		.block_row_i      (block_row_i),
		.block_col_i      (block_col_i),
		.sram_read_data_i (sram_read_data_i),
		.sram_addr_o      (fetch_addr),
		.buf_addr_o       (fetch_buf_addr),
		.buf_wdata_o      (fetch_wdata),
		.buf_we_o         (fetch_we),
		.fetch_done_o     (fetch_done)
	);

	// fetch and compute never overlap, the write strobe picks the owner of port A
	assign buf_addr_a = fetch_we ? fetch_buf_addr : comp_addr_a;

	sample_buffer u_buf (
		.clock     (clock),
		.addr_a_i  (buf_addr_a),
		.wdata_a_i (fetch_wdata),
		.we_a_i    (fetch_we),
		.addr_b_i  (comp_addr_b),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b)
	);

	for (genvar g = 0; g < 3; g++) begin : g_rom
		dct_coeff_rom u_rom (
			.idx_i   (rom_idx[g]),
			.coeff_o (rom_coeff[g])
		);
	end

	t_compute u_comp (
		.clock          (clock),
		.resetn         (resetn),
		.start_i        (compute_start),
		.buf_rdata_a_i  (rdata_a),
		.buf_rdata_b_i  (rdata_b),
		.coeff0_i       (rom_coeff[0]),
		.coeff1_i       (rom_coeff[1]),
		.coeff2_i       (rom_coeff[2]),
		.buf_addr_a_o   (comp_addr_a),
		.buf_addr_b_o   (comp_addr_b),
		.coeff_idx0_o   (rom_idx[0]),
		.coeff_idx1_o   (rom_idx[1]),
		.coeff_idx2_o   (rom_idx[2]),
		.t_value_o      (t_value),
		.t_valid_o      (t_valid),
		.compute_done_o (compute_done)
	);

	result_writer u_wr (
		.clock      (clock),
		.resetn     (resetn),
		.start_i    (compute_start),
		.t_value_i  (t_value),
		.t_valid_i  (t_valid),
		.wr_addr_o  (wr_addr),
		.wr_data_o  (wr_data),
		.wr_valid_o (wr_valid)
	);

endmodule

`default_nettype wire

// ==== dv/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model (
	input  logic                 clock,
	input  sram_pkg::sram_addr_t address_i,
	input  sram_pkg::sram_data_t write_data_i,
	input  logic                 we_n_i,
	input  logic                 load_i,      // backdoor load, used while the DUT is idle
	input  sram_pkg::sram_addr_t load_addr_i,
	input  sram_pkg::sram_data_t load_data_i,
	output sram_pkg::sram_data_t read_data_o
);
	import sram_pkg::*;

	sram_data_t mem [2**18];
	sram_addr_t addr_q;   // first read stage

	// read data shows up two cycles after its address
	always @(posedge clock) begin
		if (load_i)
			mem[load_addr_i] <= load_data_i;
		else if (!we_n_i)
			mem[address_i] <= write_data_i;
		addr_q      <= address_i;
		read_data_o <= mem[addr_q];
	end

endmodule

`default_nettype wire

// ==== dv/tb_idct.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "idct_defines.svh"

module tb_idct;
	import sram_pkg::*;

	// C[8k+j], 2048*cos((2j+1)k*pi/16), row 0 scaled by 1/sqrt(2)
	localparam int COS_TAB [64] = '{
		1448,  1448,  1448,  1448,  1448,  1448,  1448,  1448,
		2008,  1702,  1137,   399,  -399, -1137, -1702, -2008,
		1892,   783,  -783, -1892, -1892,  -783,   783,  1892,
		1702,  -399, -2008, -1137,  1137,  2008,   399, -1702,
		1448, -1448, -1448,  1448,  1448, -1448, -1448,  1448,
		1137, -2008,   399,  1702, -1702,  -399,  2008, -1137,
		783,  -1892,  1892,  -783,  -783,  1892, -1892,   783,
		399,  -1137,  1702, -2008,  2008, -1702,  1137,  -399
	};
	localparam int LOG_DEPTH    = 512;
	localparam int DONE_TIMEOUT = 2000;

	logic        clock;
	logic        resetn;
	logic        start;
	logic [4:0]  block_row;
	logic [5:0]  block_col;
	sram_addr_t  sram_address;
	sram_data_t  sram_write_data;
	sram_data_t  sram_read_data;
	logic        sram_we_n;
	logic        done;
	logic        load_en;
	sram_addr_t  load_addr;
	sram_data_t  load_data;

	int          blk [64];   // S' block under test, row-major
	logic [31:0] lcg_state;
	int          wr_count = 0;
	sram_addr_t  wr_addr_log [LOG_DEPTH];
	sram_data_t  wr_data_log [LOG_DEPTH];

	idct_top uut (
		.clock             (clock),
		.resetn            (resetn),
		.start_i           (start),
		.block_row_i       (block_row),
		.block_col_i       (block_col),
		.sram_read_data_i  (sram_read_data),
		.sram_address_o    (sram_address),
		.sram_write_data_o (sram_write_data),
		.sram_we_n_o       (sram_we_n),
		.done_o            (done)
	);

	sram_model u_sram (
		.clock        (clock),
		.address_i    (sram_address),
		.write_data_i (sram_write_data),
		.we_n_i       (sram_we_n),
		.load_i       (load_en),
		.load_addr_i  (load_addr),
		.load_data_i  (load_data),
		.read_data_o  (sram_read_data)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// log every sram write in order, outputs are stable at the falling edge
	always @(negedge clock) begin
		if (!sram_we_n) begin
			if (wr_count < LOG_DEPTH) begin
				wr_addr_log[wr_count] = sram_address;
				wr_data_log[wr_count] = sram_write_data;
			end
			wr_count = wr_count + 1;
		end
	end

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input int got, input int exp);
		$display("[FAIL] %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
		stop_run();
	endtask

	task automatic fail_text(input string msg);
		$display("%0t ns: %s", $time, msg);
		stop_run();
	endtask

	function automatic sram_data_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// T[i][j] = sum over k of S'[i][k] * C[8k+j], then >>> 8, low 16 bits
	function automatic sram_data_t expected_word(input int n);
		int i;
		int j;
		int k;
		int sum;
		int scaled;
		i   = n / 8;
		j   = n % 8;
		sum = 0;
		for (k = 0; k < 8; k++)
			sum = sum + blk[i * 8 + k] * COS_TAB[8 * k + j];
		scaled = sum >>> `T_SHIFT;
		return sram_data_t'(scaled);
	endfunction

	task automatic fill_lcg();
		int n;
		for (n = 0; n < 64; n++)
			blk[n] = $signed(lcg_next());
	endtask

	task automatic fill_checkerboard();
		int n;
		for (n = 0; n < 64; n++)
			blk[n] = (((n / 8) + (n % 8)) % 2 == 1) ? 32767 : -32768;
	endtask

	// sample i*8+k of block (row, col) in the S' plane
	task automatic load_block(input int row, input int col);
		int i;
		int k;
		for (i = 0; i < 8; i++) begin
			for (k = 0; k < 8; k++) begin
				@(negedge clock);
				load_en   = 1'b1;
				load_addr = sram_addr_t'(`SPRIME_BASE + (8 * row + i) * `IMG_WIDTH
					+ 8 * col + k);
				load_data = sram_data_t'(blk[i * 8 + k]);
			end
		end
		@(negedge clock);
		load_en = 1'b0;
	endtask

	task automatic pulse_start(input logic [4:0] row, input logic [5:0] col);
		@(negedge clock);
		block_row = row;
		block_col = col;
		start     = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < DONE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		assert (done) else fail_text("timeout: done_o never rose");
	endtask

	task automatic wait_first_write();
		int cycles;
		cycles = 0;
		while (sram_we_n && cycles < DONE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		assert (!sram_we_n) else fail_text("timeout: no sram write seen");
	endtask

	task automatic check_results(input int base);
		int n;
		sram_data_t exp;
		assert (wr_count - base == 64) else fail_value("write count", wr_count - base, 64);
		for (n = 0; n < 64; n++) begin
			exp = expected_word(n);
			assert (wr_addr_log[base + n] == sram_addr_t'(`RESULT_BASE + n))
				else fail_value("sram_address_o", int'(wr_addr_log[base + n]),
					`RESULT_BASE + n);
			assert (wr_data_log[base + n] == exp)
				else fail_value("sram_write_data_o", int'($signed(wr_data_log[base + n])),
					int'($signed(exp)));
		end
	endtask

	task automatic run_block(input logic [4:0] row, input logic [5:0] col);
		int base;
		base = wr_count;
		load_block(int'(row), int'(col));
		pulse_start(row, col);
		assert (!done) else fail_value("done_o", int'(done), 0);
		wait_done();
		check_results(base);
	endtask

	task automatic test_reset_state();
		int cyc;
		for (cyc = 0; cyc < 10; cyc++) begin
			@(negedge clock);
			assert (sram_we_n == 1'b1) else fail_value("sram_we_n_o", int'(sram_we_n), 1);
			assert (done == 1'b0) else fail_value("done_o", int'(done), 0);
		end
		assert (wr_count == 0) else fail_value("write count", wr_count, 0);
	endtask

	task automatic test_first_block();
		fill_lcg();
		run_block(5'd0, 6'd0);
	endtask

	task automatic test_last_block();
		fill_lcg();
		run_block(5'd29, 6'd39); // largest fetch offsets
	endtask

	task automatic test_checkerboard();
		fill_checkerboard();
		run_block(5'd12, 6'd20);
	endtask

	task automatic test_start_ignored();
		int base;
		int cyc;
		fill_lcg();
		base = wr_count;
		load_block(3, 17);
		pulse_start(5'd3, 6'd17);
		wait_first_write();
		pulse_start(5'd0, 6'd0);   // writer busy, must be dropped
		wait_done();
		check_results(base);
		for (cyc = 0; cyc < 40; cyc++) begin
			@(negedge clock);
			assert (done) else fail_value("done_o", int'(done), 1);
		end
		assert (wr_count - base == 64) else fail_value("write count", wr_count - base, 64);
		fill_lcg();
		run_block(5'd3, 6'd18);    // back to back, done still high
	endtask

	initial begin
		start     = 1'b0;
		block_row = '0;
		block_col = '0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		resetn    = 1'b0;
		lcg_state = 32'd9;
		repeat (16) @(negedge clock);
		resetn = 1'b1;
		test_reset_state();
		test_first_block();
		test_last_block();
		test_checkerboard();
		test_start_ignored();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/sram_pkg.sv
verilog/idct_pkg.sv
verilog/idct_controller.sv
verilog/block_fetch.sv
verilog/sample_buffer.sv
verilog/dct_coeff_rom.sv
verilog/t_compute.sv
verilog/result_writer.sv
verilog/idct_top.sv
dv/sram_model.sv
dv/tb_idct.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f src.f --top-module tb_idct -o tb_idct > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/tb_idct > sim.log 2>&1 ; cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || grep -q "Simulation passed" sim.log
